// ==== hdl/spi_flash_pkg.sv ====
package spi_flash_pkg;

    // ************************************************************************
    // Sizes
    // ************************************************************************

    // Serial clocks per transferred byte
    localparam int BYTE_BITS = 8;
    // Attached flash devices, one select each
    localparam int NCS_COUNT = 3;
    // Chip-select index width
    localparam int CS_INDEX_BITS = 4;
    // Dummy-cycle count width
    localparam int DUMMY_BITS = 5;

    // ************************************************************************
    // Types
    // ************************************************************************

    typedef logic [BYTE_BITS-1:0] byte_t;
    typedef logic [CS_INDEX_BITS-1:0] cs_index_t;
    // Active-low selects
    typedef logic [NCS_COUNT-1:0] ncs_t;
    typedef logic [DUMMY_BITS-1:0] dummy_t;
    // One spare bit above the byte count
    typedef logic [$clog2(BYTE_BITS):0] bit_cnt_t;

    // One beat of the command stream
    typedef struct packed {
        logic  sop;
        logic  eop;
        byte_t data;
    } cmd_beat_t;

    // Sequencer states
    typedef enum logic [3:0] {
        idle,
        opcode,
        load_data,
        write_data,
        dummy,
        turnaround,
        read_data,
        load_read,
        pre_complete,
        complete
    } seq_state_t;

    // Strobes to the transmit shifter
    typedef struct packed {
        logic load;
        logic shift;
    } tx_ctrl_t;

endpackage

// ==== hdl/spi_sequencer.sv ====
`timescale 1ns/100ps

module spi_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_valid,
    input  spi_flash_pkg::cmd_beat_t cmd,
    output logic                     cmd_ready,
    input  logic                     require_rdata,
    input  spi_flash_pkg::dummy_t    dummy_cycles,
    input  spi_flash_pkg::cs_index_t chip_select,
    output spi_flash_pkg::tx_ctrl_t  tx_ctrl,
    output logic                     rx_capture,
    output spi_flash_pkg::ncs_t      ncs
);
    import spi_flash_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    seq_state_t write_exit;
    logic       start;
    logic       load;
    logic       last_data;
    logic       need_dummy;
    bit_cnt_t   bit_cnt;
    logic       byte_phase;
    logic       bit_done;
    dummy_t     dummy_cnt;
    logic       dummy_done;
    logic       ncs_active;
    ncs_t       ncs_next;

    // Start beat seen in idle
    assign start = (state == idle) && cmd_valid && cmd.sop;
    // Any byte taken into the transmit shifter
    assign load = start || ((state == load_data) && cmd_valid);

    // End marker of the command held until the transaction closes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_data <= 1'b0;
        end else if (load && cmd.eop) begin
            last_data <= 1'b1;
        end else if (state == complete) begin
            last_data <= 1'b0;
        end
    end

    // Dummy phase wanted for this transaction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            need_dummy <= 1'b0;
        end else if (start) begin
            need_dummy <= (dummy_cycles != '0);
        end
    end

    // ************************************************************************
    // Command FSM
    // ************************************************************************

    // Where a finished write byte leads
    always_comb begin
        if (!last_data) begin
            write_exit = load_data;
        end else if (!require_rdata) begin
            write_exit = pre_complete;
        end else if (need_dummy) begin
            write_exit = dummy;
        end else begin
            write_exit = turnaround;
        end
    end

    always_comb begin
        state_next = state;
        cmd_ready  = 1'b0;
        case (state)
            idle: begin
                cmd_ready = 1'b1;
                if (cmd_valid && cmd.sop) begin
                    state_next = opcode;
                end
            end
            opcode, write_data: begin
                if (bit_done) begin
                    state_next = write_exit;
                end
            end
            load_data: begin
                // Waits here while the source stalls
                cmd_ready = 1'b1;
                if (cmd_valid) begin
                    state_next = write_data;
                end
            end
            dummy: begin
                if (dummy_done) begin
                    state_next = turnaround;
                end
            end
            turnaround: state_next = read_data;
            read_data: begin
                if (bit_done) begin
                    state_next = load_read;
                end
            end
            // Read continuation decided only at byte boundary
            load_read: state_next = require_rdata ? read_data : complete;
            pre_complete: state_next = complete;
            complete: state_next = idle;
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // Shift also runs past the last bit so mosi falls back to zero
    assign tx_ctrl.load  = load;
    assign tx_ctrl.shift = state inside {opcode, write_data, dummy, turnaround, pre_complete};
    // Assembly register is full at the end of this cycle
    assign rx_capture = (state == load_read);

    // ************************************************************************
    // Bit and dummy counters
    // ************************************************************************

    assign byte_phase = state inside {opcode, write_data, read_data};
    assign bit_done   = byte_phase && (bit_cnt == '0);

    // Seven counted cycles plus the load cycle make one byte
    // First read byte gets one extra cycle for the turnaround sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (load || (state == load_read)) begin
            bit_cnt <= bit_cnt_t'(BYTE_BITS - 2);
        end else if (state == turnaround) begin
            bit_cnt <= bit_cnt_t'(BYTE_BITS - 1);
        end else if (byte_phase && !bit_done) begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    assign dummy_done = (state == dummy) && (dummy_cnt == '0);

    // Preset outside the dummy phase and counts down inside it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dummy_cnt <= '0;
        end else if (state != dummy) begin
            dummy_cnt <= dummy_cycles - 1'b1;
        end else if (!dummy_done) begin
            dummy_cnt <= dummy_cnt - 1'b1;
        end
    end

    // ************************************************************************
    // Chip selects launched on the falling edge
    // ************************************************************************

    assign ncs_active = !(state inside {idle, complete});

    // One-hot decode inverted for active low
    always_comb begin
        for (int i = 0; i < NCS_COUNT; i++) begin
            ncs_next[i] = !(ncs_active && (chip_select == cs_index_t'(i)));
        end
    end

    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            ncs <= '1;
        end else begin
            ncs <= ncs_next;
        end
    end

    // A beat offered in idle has to open a command
    start_beat_a: assert property (
        @(posedge clk) disable iff (reset)
        (cmd_valid && (state == idle)) |-> cmd.sop
    );

    // Selected device stays put while the transaction runs
    select_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        (state != idle) |-> $stable(chip_select)
    );

endmodule

// ==== hdl/spi_tx_shifter.sv ====
`timescale 1ns/100ps

module spi_tx_shifter (
    input  logic                     clk,
    input  logic                     reset,
    input  spi_flash_pkg::tx_ctrl_t  tx_ctrl,
    input  spi_flash_pkg::cmd_beat_t cmd,
    output logic                     mosi
);
    import spi_flash_pkg::*;

    // Outgoing byte, MSB on top
    byte_t out_byte;

    // ************************************************************************
    // Byte register
    // ************************************************************************

    // Taken on the accepting rising edge, so the beat is stable
    // Zeros fill from below, keeping the line low once a byte is out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_byte <= '0;
        end else if (tx_ctrl.load) begin
            out_byte <= cmd.data;
        end else if (tx_ctrl.shift) begin
            out_byte <= {out_byte[BYTE_BITS-2:0], 1'b0};
        end
    end

    // ************************************************************************
    // Data line
    // ************************************************************************

    // Relaunched half a cycle later
    // Each bit is stable across the flash's rising-edge sample
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            mosi <= 1'b0;
        end else begin
            mosi <= out_byte[BYTE_BITS-1];
        end
    end

endmodule

// ==== hdl/spi_rx_shifter.sv ====
`timescale 1ns/100ps

module spi_rx_shifter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 miso,
    input  logic                 rx_capture,
    output logic                 rsp_valid,
    output spi_flash_pkg::byte_t rsp_data
);
    import spi_flash_pkg::*;

    // Last eight miso samples, newest at bit 0
    byte_t asm_byte;
    // Capture strobe, one cycle late
    logic  capture_q;

    // ************************************************************************
    // Input sampling
    // ************************************************************************

    // Free running, the sequencer picks the byte boundary
    always_ff @(posedge clk) begin
        asm_byte <= {asm_byte[BYTE_BITS-2:0], miso};
    end

    // Last bit lands in asm_byte on the edge that ends the capture cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            capture_q <= 1'b0;
        end else begin
            capture_q <= rx_capture;
        end
    end

    // ************************************************************************
    // Response register
    // ************************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= capture_q;
        end
    end

    // Holds between pulses
    always_ff @(posedge clk) begin
        if (capture_q) begin
            rsp_data <= asm_byte;
        end
    end

    // Responses are single pulses, no back-pressure
    rsp_pulse_a: assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid |=> !rsp_valid
    );

endmodule

// ==== hdl/spi_flash_master.sv ====
`timescale 1ns/100ps

module spi_flash_master (
    input  logic                     clk,
    input  logic                     reset,

    // Command stream
    input  logic                     cmd_valid,
    input  spi_flash_pkg::cmd_beat_t cmd,
    output logic                     cmd_ready,
    input  logic                     require_rdata,
    input  spi_flash_pkg::dummy_t    dummy_cycles,
    input  spi_flash_pkg::cs_index_t chip_select,

    // Read responses
    output logic                     rsp_valid,
    output spi_flash_pkg::byte_t     rsp_data,

    // Flash pins, serial clock is clk
    output spi_flash_pkg::ncs_t      ncs,
    output logic                     mosi,
    input  logic                     miso
);
    import spi_flash_pkg::*;

    tx_ctrl_t tx_ctrl;
    logic     rx_capture;

    // FSM, counters and selects
    spi_sequencer sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_ready     (cmd_ready),
        .require_rdata (require_rdata),
        .dummy_cycles  (dummy_cycles),
        .chip_select   (chip_select),
        .tx_ctrl       (tx_ctrl),
        .rx_capture    (rx_capture),
        .ncs           (ncs)
    );

    // Outgoing data line
    spi_tx_shifter tx_shifter_i (
        .clk     (clk),
        .reset   (reset),
        .tx_ctrl (tx_ctrl),
        .cmd     (cmd),
        .mosi    (mosi)
    );

    // Incoming data line
    spi_rx_shifter rx_shifter_i (
        .clk        (clk),
        .reset      (reset),
        .miso       (miso),
        .rx_capture (rx_capture),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

endmodule

// ==== test/spi_flash_model.sv ====
`timescale 1ns/100ps

module spi_flash_model (
    input  logic                clk,
    input  spi_flash_pkg::ncs_t ncs,
    input  logic                mosi,
    output logic                miso
);
    import spi_flash_pkg::*;

    // mosi samples taken while a device is selected
    logic  rec_bits[$];
    // Read data, handed out MSB first from read_start on
    byte_t rd_bytes[$];
    int    read_start;
    // Samples taken in the current select
    int    sample_cnt;
    int    bit_idx;
    byte_t cur_byte;
    // Every select bit that went low
    ncs_t  sel_seen;

    initial begin
        miso       = 1'b0;
        read_start = 32'h7fffffff;
        sample_cnt = 0;
        sel_seen   = '0;
    end

    // Flash samples its input on the rising edge
    always @(posedge clk) begin
        if (ncs != '1) begin
            rec_bits.push_back(mosi);
            sel_seen   = sel_seen | ~ncs;
            sample_cnt = sample_cnt + 1;
        end else begin
            sample_cnt = 0;
        end
    end

    // Next sample index is sample_cnt, launch its read bit half a cycle early
    always @(negedge clk) begin
        bit_idx = sample_cnt - read_start;
        if (bit_idx >= 0 && bit_idx / BYTE_BITS < rd_bytes.size()) begin
            cur_byte = rd_bytes[bit_idx / BYTE_BITS];
            miso     = cur_byte[BYTE_BITS - 1 - bit_idx % BYTE_BITS];
        end else begin
            miso = 1'b0;
        end
    end

    task automatic clear_log();
        rec_bits.delete();
        rd_bytes.delete();
        sel_seen   = '0;
        read_start = 32'h7fffffff;
    endtask

    task automatic queue_read(input byte_t data);
        rd_bytes.push_back(data);
    endtask

    task automatic set_read_start(input int index);
        read_start = index;
    endtask

    function automatic int bit_count();
        return rec_bits.size();
    endfunction

    function automatic logic bit_at(input int index);
        return rec_bits[index];
    endfunction

    function automatic ncs_t selects_seen();
        return sel_seen;
    endfunction

endmodule

// ==== test/tb_spi_flash_master.sv ====
`timescale 1ns/100ps

module tb_spi_flash_master;
    import spi_flash_pkg::*;

    localparam int N_TRANS   = 48;
    localparam int MAX_BYTES = 5;
    // Longest stall the source adds past a byte time
    localparam int MAX_GAP   = 4;
    localparam int MAX_READS = 4;
    // Worst transaction with slack for the closing cycles
    localparam int MAX_CYCLES = MAX_BYTES * (2 * BYTE_BITS + MAX_GAP) + 32
                              + (MAX_READS + 2) * BYTE_BITS + 16;

    logic      clk = 1'b0;
    logic      reset;
    logic      cmd_valid;
    cmd_beat_t cmd;
    logic      cmd_ready;
    logic      require_rdata;
    dummy_t    dummy_cycles;
    cs_index_t chip_select;
    logic      rsp_valid;
    byte_t     rsp_data;
    ncs_t      ncs;
    logic      mosi;
    logic      miso;

    integer    seed;
    int        cycle = 0;
    int        rsp_count;
    // Read bytes still to come in flash order
    byte_t     rsp_exp[$];

    always #10 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    spi_flash_master dut_i (.*);

    spi_flash_model flash_i (
        .clk  (clk),
        .ncs  (ncs),
        .mosi (mosi),
        .miso (miso)
    );

    // ************************************************************************
    // Compare tasks
    // ************************************************************************

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic byte_equal(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %02h, got %02h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic ncs_equal(input string name, input ncs_t exp, input ncs_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %b, got %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic count_equal(input string name, input integer exp, input integer act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %0d, got %0d",
                                    $time, name, exp, act));
        end
    endtask

    task automatic bit_equal(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch at %0d ns: %s expected %b, got %b",
                                    $time, name, exp, act));
        end
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    // Called on a falling edge and returns on the falling edge after the handshake
    task automatic send_beat(input cmd_beat_t beat, output int accepted);
        cmd_valid = 1'b1;
        cmd       = beat;
        while (!cmd_ready) @(negedge clk);
        @(negedge clk);
        accepted  = cycle;
        cmd_valid = 1'b0;
    endtask

    // Kind 0 writes only, 1 reads at once, 2 reads after dummy cycles
    task automatic run_transaction(input int kind);
        int        n_bytes;
        int        target;
        int        gap;
        int        acc;
        int        prev_acc;
        int        stall;
        int        i;
        int        b;
        byte_t     data;
        byte_t     prev;
        dummy_t    dcyc;
        cs_index_t cs;
        ncs_t      exp_sel;
        cmd_beat_t beat;
        logic      exp_bits[$];

        n_bytes = 1 + {$random(seed)} % MAX_BYTES;
        target  = 1 + {$random(seed)} % MAX_READS;
        cs      = cs_index_t'({$random(seed)} % NCS_COUNT);
        dcyc    = (kind == 2) ? dummy_t'(1 + {$random(seed)} % 31) : '0;
        flash_i.clear_log();
        rsp_count = 0;
        rsp_exp.delete();
        // One spare byte since the read after the target is already under way
        if (kind != 0) begin
            for (i = 0; i <= target; i++) begin
                data = byte_t'($random(seed));
                flash_i.queue_read(data);
                rsp_exp.push_back(data);
            end
        end
        // Bus idle and ready before every start beat
        bit_equal("cmd_ready", 1'b1, cmd_ready);
        ncs_equal("ncs", '1, ncs);
        require_rdata = (kind != 0);
        dummy_cycles  = dcyc;
        chip_select   = cs;
        for (i = 0; i < n_bytes; i++) begin
            if (i > 0) begin
                gap = {$random(seed)} % (BYTE_BITS + MAX_GAP);
                repeat (gap) @(negedge clk);
            end
            data      = byte_t'($random(seed));
            beat.sop  = (i == 0);
            beat.eop  = (i == n_bytes - 1);
            beat.data = data;
            send_beat(beat, acc);
            // A byte takes BYTE_BITS cycles and any stall beyond holds the last bit
            if (i > 0) begin
                stall = acc - prev_acc - BYTE_BITS;
                if (stall < 0) begin
                    stop_on_error("Command byte accepted before the previous one went out");
                end
                repeat (stall) exp_bits.push_back(prev[0]);
            end
            for (b = BYTE_BITS - 1; b >= 0; b--) begin
                exp_bits.push_back(data[b]);
            end
            prev     = data;
            prev_acc = acc;
        end
        if (kind != 0) begin
            flash_i.set_read_start(exp_bits.size() + dcyc + 1);
            // Dummy cycles and turnaround leave mosi low
            repeat (dcyc + 1) exp_bits.push_back(1'b0);
            while (rsp_count < target) @(negedge clk);
            require_rdata = 1'b0;
        end
        // Back in idle while the last response trails by up to two cycles
        while (!cmd_ready) @(negedge clk);
        repeat (3) @(negedge clk);
        if (kind != 0) begin
            // The byte after the target is already under way when require_rdata drops
            count_equal("rsp count", target + 1, rsp_count);
            repeat (BYTE_BITS * (target + 1)) exp_bits.push_back(1'b0);
        end
        exp_sel     = '0;
        exp_sel[cs] = 1'b1;
        ncs_equal("selects used", exp_sel, flash_i.selects_seen());
        count_equal("mosi bit count", exp_bits.size(), flash_i.bit_count());
        for (i = 0; i < exp_bits.size(); i++) begin
            bit_equal($sformatf("mosi bit %0d", i), exp_bits[i], flash_i.bit_at(i));
        end
        dummy_cycles = '0;
    endtask

    // Every response pulse is checked against the flash data in order
    always @(negedge clk) begin
        if (!reset && rsp_valid) begin
            if (rsp_exp.size() == 0) begin
                stop_on_error("Read response arrived with no flash byte left to match");
            end else begin
                byte_equal("rsp_data", rsp_exp.pop_front(), rsp_data);
                rsp_count = rsp_count + 1;
            end
        end
    end

    initial begin
        seed          = 32'h744fd975;
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd           = '0;
        require_rdata = 1'b0;
        dummy_cycles  = '0;
        chip_select   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        bit_equal("cmd_ready", 1'b1, cmd_ready);
        bit_equal("rsp_valid", 1'b0, rsp_valid);
        ncs_equal("ncs", '1, ncs);
        for (int t = 0; t < N_TRANS; t++) begin
            run_transaction(t % 3);
        end
        ncs_equal("ncs", '1, ncs);
        $display("TB PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(N_TRANS * MAX_CYCLES * 20 + 2000);
        stop_on_error("Run timed out, the DUT stopped making progress");
    end

endmodule

// ==== flist.f ====
hdl/spi_flash_pkg.sv
hdl/spi_sequencer.sv
hdl/spi_tx_shifter.sv
hdl/spi_rx_shifter.sv
hdl/spi_flash_master.sv
test/spi_flash_model.sv
test/tb_spi_flash_master.sv
